/* rtl/fpclass_pkg.sv */
`default_nettype none

package fpclass_pkg;

    localparam int SINGLE_EXP_WIDTH  = 8;
    localparam int SINGLE_FRAC_WIDTH = 23;
    localparam int DOUBLE_EXP_WIDTH  = 11;
    localparam int DOUBLE_FRAC_WIDTH = 52;

    localparam int SINGLE_WIDTH = 1 + SINGLE_EXP_WIDTH + SINGLE_FRAC_WIDTH;
    localparam int DOUBLE_WIDTH = 1 + DOUBLE_EXP_WIDTH + DOUBLE_FRAC_WIDTH;

    localparam int NUM_CLASSES    = 10;  // FCLASS result bits
    localparam int REG_IDX_WIDTH  = 5;
    localparam int CSR_ADDR_WIDTH = 2;
    localparam int CSR_DATA_WIDTH = 32;

    typedef logic [DOUBLE_WIDTH-1:0]     operand_t;
    typedef logic [DOUBLE_EXP_WIDTH-1:0] exp_t;   // Right-aligned
    typedef logic [DOUBLE_FRAC_WIDTH-1:0] frac_t; // Right-aligned
    typedef logic [REG_IDX_WIDTH-1:0]    reg_idx_t;
    typedef logic [NUM_CLASSES-1:0]      fclass_mask_t;
    typedef logic [CSR_ADDR_WIDTH-1:0]   csr_addr_t;
    typedef logic [CSR_DATA_WIDTH-1:0]   csr_data_t;

    localparam csr_addr_t CSR_CTRL   = 2'd0;
    localparam csr_addr_t CSR_STICKY = 2'd1;
    localparam csr_addr_t CSR_CLEAR  = 2'd2;
    localparam csr_addr_t CSR_COUNT  = 2'd3;

    typedef enum logic
    {
        prec_single = 1'b0,
        prec_double = 1'b1
    } precision_e;

    // Values follow the FCLASS result bit order
    typedef enum logic [3:0]
    {
        class_neg_inf       = 4'd0,
        class_neg_normal    = 4'd1,
        class_neg_subnormal = 4'd2,
        class_neg_zero      = 4'd3,
        class_pos_zero      = 4'd4,
        class_pos_subnormal = 4'd5,
        class_pos_normal    = 4'd6,
        class_pos_inf       = 4'd7,
        class_snan          = 4'd8,
        class_qnan          = 4'd9
    } fp_class_e;

endpackage

`default_nettype wire

/* rtl/fp_operand_unpack.sv */
`default_nettype none

module fp_operand_unpack
(
    input  wire                     clk,
    input  wire                     reset,

    input  wire                     in_valid,
    input  fpclass_pkg::operand_t   in_operand,
    input  fpclass_pkg::precision_e in_precision,
    input  fpclass_pkg::reg_idx_t   in_tag,

    input  wire                     nan_box_check_enable,

    output logic                    unp_valid,
    output logic                    unp_sign,
    output fpclass_pkg::exp_t       unp_exp,
    output fpclass_pkg::frac_t      unp_frac,
    output fpclass_pkg::precision_e unp_precision,
    output logic                    unp_box_fault,
    output fpclass_pkg::reg_idx_t   unp_tag
);

    import fpclass_pkg::*;

    logic  sign_sel;
    exp_t  exp_sel;
    frac_t frac_sel;
    logic  upper_all_ones;
    logic  box_fault_sel;

    assign upper_all_ones = &in_operand[DOUBLE_WIDTH-1:SINGLE_WIDTH];

    always_comb
    begin
        if (in_precision == prec_single)
        begin
            sign_sel = in_operand[SINGLE_WIDTH-1];
            exp_sel  = exp_t'(in_operand[SINGLE_WIDTH-2 -: SINGLE_EXP_WIDTH]);
            frac_sel = frac_t'(in_operand[SINGLE_FRAC_WIDTH-1:0]);
        end
        else
        begin
            sign_sel = in_operand[DOUBLE_WIDTH-1];
            exp_sel  = in_operand[DOUBLE_WIDTH-2 -: DOUBLE_EXP_WIDTH];
            frac_sel = in_operand[DOUBLE_FRAC_WIDTH-1:0];
        end
    end

    // Singles must carry all ones in the upper word
    assign box_fault_sel = nan_box_check_enable
                         && (in_precision == prec_single)
                         && !upper_all_ones;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            unp_valid <= 1'b0;
        end
        else
        begin
            unp_valid <= in_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (in_valid)  // Fields held between requests
        begin
            unp_sign      <= sign_sel;
            unp_exp       <= exp_sel;
            unp_frac      <= frac_sel;
            unp_precision <= in_precision;
            unp_box_fault <= box_fault_sel;
            unp_tag       <= in_tag;
        end
    end

endmodule

`default_nettype wire

/* rtl/fp_classify.sv */
`default_nettype none

module fp_classify
(
    input  wire                     unp_sign,
    input  fpclass_pkg::exp_t       unp_exp,
    input  fpclass_pkg::frac_t      unp_frac,
    input  fpclass_pkg::precision_e unp_precision,
    input  wire                     unp_box_fault,

    output fpclass_pkg::fp_class_e  class_code
);

    import fpclass_pkg::*;

    logic exp_all_zeros;
    logic exp_all_ones;
    logic frac_all_zeros;
    logic frac_msb;

    // Only the low bits of the format in use are examined
    always_comb
    begin
        if (unp_precision == prec_single)
        begin
            exp_all_zeros  = ~|unp_exp[SINGLE_EXP_WIDTH-1:0];
            exp_all_ones   = &unp_exp[SINGLE_EXP_WIDTH-1:0];
            frac_all_zeros = ~|unp_frac[SINGLE_FRAC_WIDTH-1:0];
            frac_msb       = unp_frac[SINGLE_FRAC_WIDTH-1];
        end
        else
        begin
            exp_all_zeros  = ~|unp_exp[DOUBLE_EXP_WIDTH-1:0];
            exp_all_ones   = &unp_exp[DOUBLE_EXP_WIDTH-1:0];
            frac_all_zeros = ~|unp_frac[DOUBLE_FRAC_WIDTH-1:0];
            frac_msb       = unp_frac[DOUBLE_FRAC_WIDTH-1];
        end
    end

    always_comb
    begin
        if (unp_box_fault)
        begin
            class_code = class_qnan;  // Improperly boxed single reads as canonical NaN
        end
        else if (exp_all_ones)
        begin
            if (frac_all_zeros)
            begin
                class_code = unp_sign ? class_neg_inf : class_pos_inf;
            end
            else if (frac_msb)
            begin
                class_code = class_qnan;
            end
            else
            begin
                class_code = class_snan;
            end
        end
        else if (exp_all_zeros)
        begin
            if (frac_all_zeros)
            begin
                class_code = unp_sign ? class_neg_zero : class_pos_zero;
            end
            else
            begin
                class_code = unp_sign ? class_neg_subnormal : class_pos_subnormal;
            end
        end
        else
        begin
            class_code = unp_sign ? class_neg_normal : class_pos_normal;
        end
    end

endmodule

`default_nettype wire

/* rtl/fclass_writeback.sv */
`default_nettype none

module fclass_writeback
(
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       unp_valid,
    input  fpclass_pkg::reg_idx_t     unp_tag,
    input  fpclass_pkg::fp_class_e    class_code,

    output logic                      result_valid,
    output fpclass_pkg::operand_t     result_mask,
    output fpclass_pkg::reg_idx_t     result_tag,

    output logic                      wb_valid,
    output fpclass_pkg::fclass_mask_t wb_mask
);

    import fpclass_pkg::*;

    fclass_mask_t mask_next;
    fclass_mask_t mask_q;
    logic         valid_q;

    assign mask_next = fclass_mask_t'(1) << class_code;  // One bit per class

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= unp_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (unp_valid)
        begin
            mask_q     <= mask_next;
            result_tag <= unp_tag;
        end
    end

    assign result_valid = valid_q;
    assign result_mask  = operand_t'(mask_q);  // Zero-extended to register width

    // Status side sees the result in the same cycle
    assign wb_valid = valid_q;
    assign wb_mask  = mask_q;

endmodule

`default_nettype wire

/* rtl/fclass_csr.sv */
`default_nettype none

module fclass_csr
(
    input  wire                       clk,
    input  wire                       reset,

    input  wire                       csr_write,
    input  wire                       csr_read,
    input  fpclass_pkg::csr_addr_t    csr_addr,
    input  fpclass_pkg::csr_data_t    csr_wdata,
    output fpclass_pkg::csr_data_t    csr_rdata,
    output logic                      csr_rdata_valid,

    input  wire                       wb_valid,
    input  fpclass_pkg::fclass_mask_t wb_mask,

    output logic                      nan_box_check_enable
);

    import fpclass_pkg::*;

    logic         ctrl_q;
    fclass_mask_t sticky_q;
    csr_data_t    count_q;
    logic         clear_hit;
    csr_data_t    read_value;

    assign clear_hit = csr_write && (csr_addr == CSR_CLEAR);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ctrl_q <= 1'b1;  // Box check on out of reset
        end
        else if (csr_write && (csr_addr == CSR_CTRL))
        begin
            ctrl_q <= csr_wdata[0];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || clear_hit)  // Clear beats a same-cycle result
        begin
            sticky_q <= '0;
            count_q  <= '0;
        end
        else if (wb_valid)
        begin
            sticky_q <= sticky_q | wb_mask;
            count_q  <= count_q + 1'b1;  // Wraps
        end
    end

    always_comb
    begin
        case (csr_addr)
            CSR_CTRL:   read_value = csr_data_t'(ctrl_q);
            CSR_STICKY: read_value = csr_data_t'(sticky_q);
            CSR_COUNT:  read_value = count_q;
            default:    read_value = '0;  // CLEAR is write-only
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            csr_rdata_valid <= 1'b0;
        end
        else
        begin
            csr_rdata_valid <= csr_read;
        end
    end

    always_ff @(posedge clk)
    begin
        if (csr_read)
        begin
            csr_rdata <= read_value;
        end
    end

    assign nan_box_check_enable = ctrl_q;

endmodule

`default_nettype wire

/* rtl/fp_classify_top.sv */
`default_nettype none

module fp_classify_top
(
    input  wire                     clk,
    input  wire                     reset,

    input  wire                     in_valid,
    input  fpclass_pkg::operand_t   in_operand,
    input  fpclass_pkg::precision_e in_precision,
    input  fpclass_pkg::reg_idx_t   in_tag,

    output logic                    result_valid,
    output fpclass_pkg::operand_t   result_mask,
    output fpclass_pkg::reg_idx_t   result_tag,

    input  wire                     csr_write,
    input  wire                     csr_read,
    input  fpclass_pkg::csr_addr_t  csr_addr,
    input  fpclass_pkg::csr_data_t  csr_wdata,
    output fpclass_pkg::csr_data_t  csr_rdata,
    output logic                    csr_rdata_valid
);

    import fpclass_pkg::*;

    logic         nan_box_check_enable;
    logic         unp_valid;
    logic         unp_sign;
    exp_t         unp_exp;
    frac_t        unp_frac;
    precision_e   unp_precision;
    logic         unp_box_fault;
    reg_idx_t     unp_tag;
    fp_class_e    class_code;
    logic         wb_valid;
    fclass_mask_t wb_mask;

    fp_operand_unpack u_unpack
    (
        .clk                  (clk),
        .reset                (reset),
        .in_valid             (in_valid),
        .in_operand           (in_operand),
        .in_precision         (in_precision),
        .in_tag               (in_tag),
        .nan_box_check_enable (nan_box_check_enable),
        .unp_valid            (unp_valid),
        .unp_sign             (unp_sign),
        .unp_exp              (unp_exp),
        .unp_frac             (unp_frac),
        .unp_precision        (unp_precision),
        .unp_box_fault        (unp_box_fault),
        .unp_tag              (unp_tag)
    );

    fp_classify u_classify
    (
        .unp_sign      (unp_sign),
        .unp_exp       (unp_exp),
        .unp_frac      (unp_frac),
        .unp_precision (unp_precision),
        .unp_box_fault (unp_box_fault),
        .class_code    (class_code)
    );

    fclass_writeback u_writeback
    (
        .clk          (clk),
        .reset        (reset),
        .unp_valid    (unp_valid),
        .unp_tag      (unp_tag),
        .class_code   (class_code),
        .result_valid (result_valid),
        .result_mask  (result_mask),
        .result_tag   (result_tag),
        .wb_valid     (wb_valid),
        .wb_mask      (wb_mask)
    );

    fclass_csr u_csr
    (
        .clk                  (clk),
        .reset                (reset),
        .csr_write            (csr_write),
        .csr_read             (csr_read),
        .csr_addr             (csr_addr),
        .csr_wdata            (csr_wdata),
        .csr_rdata            (csr_rdata),
        .csr_rdata_valid      (csr_rdata_valid),
        .wb_valid             (wb_valid),
        .wb_mask              (wb_mask),
        .nan_box_check_enable (nan_box_check_enable)
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;  // Period of 10

endmodule

`default_nettype wire

/* dv/fp_classify_tb.sv */
`default_nettype none

module fp_classify_tb;

    import fpclass_pkg::*;

    logic       clk;
    logic       reset;
    logic       in_valid;
    operand_t   in_operand;
    precision_e in_precision;
    reg_idx_t   in_tag;
    logic       result_valid;
    operand_t   result_mask;
    reg_idx_t   result_tag;
    logic       csr_write;
    logic       csr_read;
    csr_addr_t  csr_addr;
    csr_data_t  csr_wdata;
    csr_data_t  csr_rdata;
    logic       csr_rdata_valid;

    logic [14:0]  expect_q[$];  // Tag above mask
    string        test_name;
    int           error_count;
    int           tests_run;
    int           tests_failed;
    int           errors_at_start;
    integer       seed;
    logic [1:0]   valid_hist;
    bit           box_check;
    fclass_mask_t sticky_model;
    int           op_count;

    tb_clock_gen u_clock (.clk(clk));

    fp_classify_top dut0
    (
        .clk (clk), .reset (reset),
        .in_valid (in_valid), .in_operand (in_operand),
        .in_precision (in_precision), .in_tag (in_tag),
        .result_valid (result_valid), .result_mask (result_mask), .result_tag (result_tag),
        .csr_write (csr_write), .csr_read (csr_read), .csr_addr (csr_addr),
        .csr_wdata (csr_wdata), .csr_rdata (csr_rdata), .csr_rdata_valid (csr_rdata_valid)
    );

    task automatic report_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        $display("Error: %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
        error_count++;
    endtask

    task automatic abort_run(input string what);
        $display("%s: %s", test_name, what);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Reference model, straight from the FCLASS rules
    function automatic fp_class_e model_class(input operand_t op, input precision_e prec,
                                             input bit check);
        logic sign;
        logic e_zero;
        logic e_ones;
        logic f_zero;
        logic quiet;
        if (prec == prec_single)
        begin
            if (check && op[63:32] != 32'hffff_ffff)
                return class_qnan;
            sign   = op[31];
            e_zero = (op[30:23] == 8'h00);
            e_ones = (op[30:23] == 8'hff);
            f_zero = (op[22:0] == 23'd0);
            quiet  = op[22];
        end
        else
        begin
            sign   = op[63];
            e_zero = (op[62:52] == 11'h000);
            e_ones = (op[62:52] == 11'h7ff);
            f_zero = (op[51:0] == 52'd0);
            quiet  = op[51];
        end
        if (e_ones && f_zero)
            return sign ? class_neg_inf : class_pos_inf;
        if (e_ones)
            return quiet ? class_qnan : class_snan;
        if (e_zero && f_zero)
            return sign ? class_neg_zero : class_pos_zero;
        if (e_zero)
            return sign ? class_neg_subnormal : class_pos_subnormal;
        return sign ? class_neg_normal : class_pos_normal;
    endfunction

    // Result checks, sampled mid-cycle where outputs are stable
    always @(negedge clk)
    begin : result_check
        logic [14:0] head;
        if (!reset)
        begin
            assert (result_valid === valid_hist[1])
                else report_mismatch("result_valid", valid_hist[1], result_valid);
            if (result_valid && expect_q.size() == 0)
            begin
                $display("%s: a result arrived with no operation outstanding", test_name);
                error_count++;
            end
            else if (result_valid)
            begin
                head = expect_q.pop_front();
                assert (result_mask === operand_t'(head[9:0]))
                    else report_mismatch("result_mask", operand_t'(head[9:0]), result_mask);
                assert (result_tag === head[14:10])
                    else report_mismatch("result_tag", head[14:10], result_tag);
            end
        end
        valid_hist = {valid_hist[0], in_valid};
    end

    task automatic issue_op(input operand_t op, input precision_e prec, input reg_idx_t tag,
                            input fp_class_e cls);
        fclass_mask_t mask;
        mask = '0;
        mask[cls] = 1'b1;
        @(posedge clk);
        #1;
        in_valid     = 1'b1;
        in_operand   = op;
        in_precision = prec;
        in_tag       = tag;
        expect_q.push_back({tag, mask});
        sticky_model = sticky_model | mask;
        op_count++;
    endtask

    task automatic stop_ops();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (expect_q.size() != 0)
        begin
            if (cycles == limit)
                abort_run("timed out waiting for outstanding results");
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic write_csr(input csr_addr_t addr, input csr_data_t data);
        @(posedge clk);
        #1;
        csr_write = 1'b1;
        csr_addr  = addr;
        csr_wdata = data;
        @(posedge clk);
        #1;
        csr_write = 1'b0;
    endtask

    task automatic check_csr(input csr_addr_t addr, input csr_data_t expected, input int limit);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        csr_read = 1'b1;
        csr_addr = addr;
        @(posedge clk);
        #1;
        csr_read = 1'b0;
        @(negedge clk);
        while (!csr_rdata_valid)
        begin
            if (cycles == limit)
                abort_run("timed out waiting for csr_rdata_valid");
            @(negedge clk);
            cycles++;
        end
        assert (cycles == 0)  // Data due one cycle after the read
            else report_mismatch("csr_rdata_valid latency", 1, cycles + 1);
        assert (csr_rdata === expected)
            else report_mismatch($sformatf("CSR %0d", addr), expected, csr_rdata);
    endtask

    // Biased toward the special exponents so every class shows up
    task automatic gen_operand(output operand_t op, output precision_e prec);
        int kind;
        int fsel;
        op   = {$random(seed), $random(seed)};
        prec = precision_e'($random(seed) & 1);
        kind = $random(seed) & 7;
        fsel = $random(seed) & 3;
        if (prec == prec_single)
        begin
            if (kind != 7)
                op[63:32] = '1;
            if (kind < 2)
                op[30:23] = '0;
            else if (kind < 4)
                op[30:23] = '1;
            if (fsel == 0)
                op[22:0] = '0;
        end
        else
        begin
            if (kind < 2)
                op[62:52] = '0;
            else if (kind < 4)
                op[62:52] = '1;
            if (fsel == 0)
                op[51:0] = '0;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == errors_at_start)
            $display("%s: ok", test_name);
        else
        begin
            $display("%s: FAIL with %0d errors", test_name, error_count - errors_at_start);
            tests_failed++;
        end
    endtask

    initial
    begin
        operand_t   single_ops[10];
        operand_t   double_ops[10];
        operand_t   op;
        precision_e prec;
        reg_idx_t   tag;

        reset = 1'b1;
        in_valid = 1'b0;
        in_operand = '0;
        in_precision = prec_single;
        in_tag = '0;
        csr_write = 1'b0;
        csr_read = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        valid_hist = '0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 32'h1bef0454;
        box_check = 1'b1;
        sticky_model = '0;
        op_count = 0;
        test_name = "reset";

        single_ops = '{32'hff80_0000, 32'hbf80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0,
                       32'h0040_0000, 32'h3f80_0000, 32'h7f80_0000, 32'h7f80_0001, 32'h7fc0_0000};
        double_ops = '{64'hfff0_0000_0000_0000, 64'hbff0_0000_0000_0000, 64'h8000_0000_0000_0001,
                       64'h8000_0000_0000_0000, 64'h0, 64'h0008_0000_0000_0000,
                       64'h3ff0_0000_0000_0000, 64'h7ff0_0000_0000_0000,
                       64'h7ff0_0000_0000_0001, 64'h7ff8_0000_0000_0000};

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        begin_test("reset_state");
        @(negedge clk);
        assert (result_valid === 1'b0) else report_mismatch("result_valid", 0, result_valid);
        assert (csr_rdata_valid === 1'b0)
            else report_mismatch("csr_rdata_valid", 0, csr_rdata_valid);
        check_csr(CSR_CTRL, 32'd1, 8);
        check_csr(CSR_STICKY, 32'd0, 8);
        check_csr(CSR_COUNT, 32'd0, 8);
        end_test();

        begin_test("directed_classes");
        for (int i = 0; i < 10; i++)
            issue_op({32'hffff_ffff, single_ops[i][31:0]}, prec_single, reg_idx_t'(i),
                     fp_class_e'(i));
        for (int i = 0; i < 10; i++)
            issue_op(double_ops[i], prec_double, reg_idx_t'(10 + i), fp_class_e'(i));
        stop_ops();
        wait_drain(20);
        end_test();

        begin_test("nan_boxing");
        op = 64'h1234_5678_3f80_0000;  // Upper word not all ones
        issue_op(op, prec_single, 5'd3, model_class(op, prec_single, box_check));
        stop_ops();
        wait_drain(20);
        write_csr(CSR_CTRL, 32'd0);
        box_check = 1'b0;
        issue_op(op, prec_single, 5'd4, model_class(op, prec_single, box_check));
        stop_ops();
        wait_drain(20);
        write_csr(CSR_CTRL, 32'd1);
        box_check = 1'b1;
        end_test();

        begin_test("back_to_back_stream");
        for (int i = 0; i < 200; i++)
        begin
            gen_operand(op, prec);
            tag = reg_idx_t'($random(seed));
            issue_op(op, prec, tag, model_class(op, prec, box_check));
        end
        stop_ops();
        wait_drain(20);
        end_test();

        begin_test("status_registers");
        check_csr(CSR_STICKY, csr_data_t'(sticky_model), 8);
        check_csr(CSR_COUNT, csr_data_t'(op_count), 8);
        write_csr(CSR_CLEAR, 32'hffff_ffff);
        check_csr(CSR_STICKY, 32'd0, 8);
        check_csr(CSR_COUNT, 32'd0, 8);
        end_test();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
rtl/fpclass_pkg.sv
rtl/fp_operand_unpack.sv
rtl/fp_classify.sv
rtl/fclass_writeback.sv
rtl/fclass_csr.sv
rtl/fp_classify_top.sv
dv/tb_clock_gen.sv
dv/fp_classify_tb.sv

/* Bender.yml */
package:
  name: fp_classify

sources:
  - rtl/fpclass_pkg.sv
  - rtl/fp_operand_unpack.sv
  - rtl/fp_classify.sv
  - rtl/fclass_writeback.sv
  - rtl/fclass_csr.sv
  - rtl/fp_classify_top.sv
  - target: simulation
    files:
      - dv/tb_clock_gen.sv
      - dv/fp_classify_tb.sv
